// File: bench/tb_cache_top.sv
module tb_cache_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 4;
    localparam int burst_len    = 16;
    localparam int random_ops   = 200;
    localparam int num_tests    = 6;

    // Worst single transfer is a read miss queued behind a full queue of writes
    localparam int worst_op_cycles = 24;
    localparam int total_ops       = 4 + 5 + 30 + (burst_len + 1) + 4 + random_ops;
    localparam int timeout_cycles  =
        2 * (reset_cycles + total_ops * worst_op_cycles + num_tests * 2);

    localparam logic [31:0] lfsr_seed = 32'h04067ffc;
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   psel;
    logic                                   penable;
    logic                                   pwrite;
    logic [cache_pkg::addr_width-1:0]       paddr;
    logic [cache_pkg::word_width-1:0]       pwdata;
    logic [cache_pkg::word_bytes-1:0]       pstrb;
    logic [cache_pkg::word_width-1:0]       prdata;
    logic                                   pready;
    logic                                   pslverr;

    // Reference image of memory, one entry per word address
    logic [31:0]    model [256];
    logic [31:0]    exp_data;
    logic [31:0]    lfsr;
    int             errors;
    int             errors_at_open;
    int             reads_checked;
    int             tests_ok;
    int             tests_bad;
    int             test_index;
    int             cycle_count;
    string          test_name;

    cache_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, an APB transfer never completed", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    read_data_check: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !pwrite && pready && !pslverr) |-> (prdata == exp_data))
    else begin
        $display("ERR %0t read of 0x%03h returned 0x%08h, expected 0x%08h", $time,
                 $sampled(paddr), $sampled(prdata), $sampled(exp_data));
        errors++;
    end

    err_only_unaligned: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable && paddr[1:0] != 2'b00))
    else begin
        $display("ERR %0t pslverr raised for aligned address 0x%03h", $time, $sampled(paddr));
        errors++;
    end

    unaligned_gets_err: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && pready && paddr[1:0] != 2'b00) |-> pslverr)
    else begin
        $display("ERR %0t unaligned address 0x%03h completed without pslverr", $time,
                 $sampled(paddr));
        errors++;
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> (!pready && !pslverr))
    else begin
        $display("ERR %0t pready or pslverr high during reset", $time);
        errors++;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic logic [9:0] byte_addr(input logic [2:0] tag, input logic [2:0] set,
                                             input logic [1:0] wsel);
        return {tag, set, wsel, 2'b00};
    endfunction

    // Byte strobe rule: only strobed bytes take the new data
    function automatic void merge_model(input logic [7:0] waddr, input logic [31:0] data,
                                        input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model[waddr][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endfunction

    task automatic write_word(input logic [9:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output int waits);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        @(posedge clk);
        while (!pready) begin
            waits++;
            @(posedge clk);
        end
        if (addr[1:0] == 2'b00) begin
            merge_model(addr[9:2], data, strb);
        end
    endtask

    task automatic read_word(input logic [9:0] addr);
        @(negedge clk);
        psel     = 1'b1;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = addr;
        exp_data = model[addr[9:2]];
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        if (addr[1:0] == 2'b00) begin
            reads_checked++;
        end
    endtask

    task automatic open_test(input string name);
        test_name      = name;
        errors_at_open = errors;
    endtask

    task automatic close_test();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        test_index++;
        if (errors == errors_at_open) begin
            tests_ok++;
            $display("test %0d %s: pass", test_index, test_name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", test_index, test_name, errors - errors_at_open);
        end
    endtask

    task automatic reads_after_reset();
        open_test("reads after reset");
        read_word(byte_addr(3'd0, 3'd0, 2'd0));
        read_word(byte_addr(3'd7, 3'd7, 2'd3));
        read_word(byte_addr(3'd2, 3'd5, 2'd1));
        read_word(byte_addr(3'd4, 3'd1, 2'd2));
        close_test();
    endtask

    task automatic partial_strobe();
        logic [9:0] x;
        int         waits;
        open_test("partial strobe merge");
        x = byte_addr(3'd1, 3'd3, 2'd2);
        write_word(x, 32'h11223344, 4'b1111, waits);
        // Line is not cached yet so only the line memory merges these bytes
        write_word(x, 32'haabbccdd, 4'b0101, waits);
        read_word(x);
        // Line is now cached, so this write hits
        write_word(x, 32'h99000000, 4'b1000, waits);
        read_word(x);
        close_test();
    endtask

    task automatic same_set_rotation();
        logic [9:0]  addrs [3];
        logic [31:0] r;
        int          waits;
        open_test("same set rotation");
        for (int l = 0; l < 3; l++) begin
            addrs[l] = byte_addr(3'(l + 1), 3'd6, 2'(l));
            write_word(addrs[l], take_bits(32), 4'b1111, waits);
        end
        // Three lines in two ways, so every first read in a round misses
        for (int round = 0; round < 3; round++) begin
            for (int l = 0; l < 3; l++) begin
                read_word(addrs[l]);
                r = take_bits(4);
                write_word(addrs[l], take_bits(32), r[3:0], waits);
                read_word(addrs[l]);
            end
        end
        close_test();
    endtask

    task automatic write_burst();
        int stall_cycles;
        int waits;
        open_test("write burst back-pressure");
        stall_cycles = 0;
        // Port posts a write every two cycles while the bank retires one every three
        for (int i = 0; i < burst_len; i++) begin
            write_word(byte_addr(3'd4, 3'd2, 2'(i % 3)), 32'hc0de0000 + i, 4'b1111, waits);
            stall_cycles += waits;
        end
        read_word(byte_addr(3'd4, 3'd2, 2'd0));
        assert (stall_cycles > 0) else begin
            $display("Write burst never stalled, the queue did not apply back-pressure");
            errors++;
        end
        close_test();
    endtask

    task automatic unaligned_access();
        logic [9:0] z;
        int         waits;
        open_test("unaligned access");
        z = byte_addr(3'd6, 3'd4, 2'd1);
        write_word(z, 32'h5a5a0f0f, 4'b1111, waits);
        write_word(z | 10'd1, 32'hffffffff, 4'b1111, waits);
        read_word(z | 10'd2);
        read_word(z);
        close_test();
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] data;
        logic [7:0]  waddr;
        logic [3:0]  strb;
        logic        is_write;
        int          waits;
        open_test("random traffic");
        for (int i = 0; i < random_ops; i++) begin
            r        = take_bits(1);
            is_write = r[0];
            r        = take_bits(8);
            waddr    = r[7:0];
            if (is_write) begin
                data = take_bits(32);
                r    = take_bits(4);
                strb = r[3:0];
                write_word({waddr, 2'b00}, data, strb, waits);
            end else begin
                read_word({waddr, 2'b00});
            end
        end
        close_test();
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        pstrb          = '0;
        exp_data       = '0;
        lfsr           = lfsr_seed;
        errors         = 0;
        errors_at_open = 0;
        reads_checked  = 0;
        tests_ok       = 0;
        tests_bad      = 0;
        test_index     = 0;
        cycle_count    = 0;
        for (int i = 0; i < 256; i++) begin
            model[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reads_after_reset();
        partial_strobe();
        same_set_rotation();
        write_burst();
        unaligned_access();
        random_traffic();

        repeat (2) @(posedge clk);
        $display("tests passed %0d, tests with errors %0d, reads checked %0d, errors %0d",
                 tests_ok, tests_bad, reads_checked, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/cache_pkg.sv
verilog/cache_req_if.sv
verilog/mem_if.sv
verilog/apb_req_port.sv
verilog/req_queue.sv
verilog/data_access.sv
verilog/cache_bank.sv
verilog/line_memory.sv
verilog/cache_top.sv
bench/tb_cache_top.sv

// File: run.sh
#!/bin/sh
# Build and run the cache bank testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_top \
    -f list.f

out=$(./obj_dir/Vtb_cache_top)
echo "$out"

echo "$out" | grep -qx "ALL CHECKS PASSED"

// File: verilog/apb_req_port.sv
module apb_req_port (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [cache_pkg::addr_width-1:0]    paddr,
    input  logic [cache_pkg::word_width-1:0]    pwdata,
    input  logic [cache_pkg::word_bytes-1:0]    pstrb,
    output logic [cache_pkg::word_width-1:0]    prdata,
    output logic                                pready,
    output logic                                pslverr,
    cache_req_if.producer                       req,
    input  logic                                rsp_valid,
    input  logic [cache_pkg::word_width-1:0]    rsp_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_push,
        st_await
    } state_t;

    state_t                state;
    logic                  aligned;
    logic                  setup;
    logic                  access;
    cache_pkg::cache_req_t pending;

    assign aligned = (paddr[1:0] == 2'b00);
    assign setup   = psel && !penable;
    assign access  = psel && penable;

    // APB inputs are stable through the access phase
    always_comb begin
        pending.op   = pwrite ? cache_pkg::op_write : cache_pkg::op_read;
        pending.addr = paddr[cache_pkg::addr_width-1:2];
        pending.data = pwdata;
        pending.strb = pstrb;
    end

    assign req.valid = (state == st_push);
    assign req.req   = pending;

    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        case (state)
            // Only an unaligned transfer reaches its access phase here
            st_idle: begin
                if (access && !aligned) begin
                    pready  = 1'b1;
                    pslverr = 1'b1;
                end
            end
            // Writes are posted as soon as the queue takes them
            st_push:  pready = pwrite && req.ready;
            st_await: pready = rsp_valid;
            default:  pready = 1'b0;
        endcase
    end

    assign prdata = rsp_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (setup && aligned) begin
                        state <= st_push;
                    end
                end
                st_push: begin
                    if (req.ready) begin
                        state <= pwrite ? st_idle : st_await;
                    end
                end
                st_await: begin
                    if (rsp_valid) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: verilog/cache_bank.sv
module cache_bank (
    input  logic                                clk,
    input  logic                                rst_n,
    cache_req_if.consumer                       req,
    mem_if.bank                                 mem,
    output logic                                rsp_valid,
    output logic [cache_pkg::word_width-1:0]    rsp_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_fill_wait,
        st_respond
    } state_t;

    state_t                                 state;
    cache_pkg::cache_req_t                  cur;
    logic                                   fill_done;
    logic [cache_pkg::num_ways-1:0]         tag_valid [cache_pkg::num_sets];
    logic [cache_pkg::tag_bits-1:0]         tag_mem [cache_pkg::num_sets][cache_pkg::num_ways];
    logic [cache_pkg::num_sets-1:0]         victim;
    logic [cache_pkg::num_ways-1:0]         hit;
    logic [cache_pkg::num_ways-1:0]         victim_sel;
    logic [cache_pkg::num_ways-1:0]         way_sel;
    logic [cache_pkg::set_bits-1:0]         ram_set;
    logic                                   is_read;
    logic                                   fill_en;
    logic                                   write_en;

    assign req.ready = (state == st_idle);
    assign is_read   = (cur.op == cache_pkg::op_read);

    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            hit[w] = tag_valid[cur.addr.set][w] && (tag_mem[cur.addr.set][w] == cur.addr.tag);
        end
        victim_sel = '0;
        victim_sel[victim[cur.addr.set]] = 1'b1;
    end

    // Data RAM reads the popped set during the idle cycle
    assign ram_set = (state == st_idle) ? req.req.addr.set : cur.addr.set;

    always_comb begin
        case (state)
            st_fill_wait: way_sel = victim_sel;
            default:      way_sel = hit;
        endcase
    end

    assign fill_en  = (state == st_fill_wait) && mem.fill_valid;
    assign write_en = (state == st_respond) && !is_read && (hit != '0);

    data_access u_data (
        .clk        (clk),
        .set        (ram_set),
        .wsel       (cur.addr.wsel),
        .write      (write_en),
        .fill       (fill_en),
        .byteen     (cur.strb),
        .write_data (cur.data),
        .fill_data  (mem.fill_data),
        .way_sel    (way_sel),
        .read_data  (rsp_data)
    );

    assign rsp_valid = (state == st_respond) && is_read;

    // Every write goes through, hit or miss
    assign mem.wr_valid = (state == st_respond) && !is_read;
    assign mem.wr_addr  = cur.addr;
    assign mem.wr_data  = cur.data;
    assign mem.wr_strb  = cur.strb;
    assign mem.rd_valid = (state == st_lookup) && is_read && (hit == '0);
    assign mem.rd_line  = {cur.addr.tag, cur.addr.set};

    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            cur <= req.req;
        end
        if (fill_en) begin
            tag_mem[cur.addr.set][victim[cur.addr.set]] <= cur.addr.tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            fill_done <= 1'b0;
            victim    <= '0;
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                tag_valid[s] <= '0;
            end
        end else begin
            case (state)
                st_idle: begin
                    if (req.valid) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    state <= (is_read && hit == '0) ? st_fill_wait : st_respond;
                end
                st_fill_wait: begin
                    // One extra cycle lets the RAM read back the new line
                    if (fill_done) begin
                        fill_done <= 1'b0;
                        state     <= st_lookup;
                    end else if (mem.fill_valid) begin
                        fill_done <= 1'b1;
                        tag_valid[cur.addr.set][victim[cur.addr.set]] <= 1'b1;
                        victim[cur.addr.set] <= ~victim[cur.addr.set];
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: verilog/cache_pkg.sv
package cache_pkg;

    // Byte address and word geometry
    localparam int addr_width     = 10;
    localparam int word_width     = 32;
    localparam int word_bytes     = 4;
    localparam int words_per_line = 4;
    localparam int word_sel_bits  = 2;

    // Bank organisation
    localparam int num_sets = 8;
    localparam int set_bits = 3;
    localparam int num_ways = 2;
    localparam int tag_bits = 3;

    // Backing store
    localparam int mem_lines      = 64;
    localparam int line_addr_bits = 6;
    localparam int mem_latency    = 4;

    localparam int queue_depth = 4;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } req_op_t;

    // Word address split as tag, set index and word select
    typedef struct packed {
        logic [tag_bits-1:0]      tag;
        logic [set_bits-1:0]      set;
        logic [word_sel_bits-1:0] wsel;
    } word_addr_t;

    typedef logic [words_per_line-1:0][word_width-1:0] line_t;

    typedef struct packed {
        req_op_t                 op;
        word_addr_t              addr;
        logic [word_width-1:0]   data;
        logic [word_bytes-1:0]   strb;
    } cache_req_t;

endpackage

// File: verilog/cache_req_if.sv
interface cache_req_if;

    logic                  valid;
    logic                  ready;
    cache_pkg::cache_req_t req;

    // Valid holds with stable req until the handshake
    modport producer (
        output valid,
        output req,
        input  ready
    );

    modport consumer (
        input  valid,
        input  req,
        output ready
    );

endinterface

// File: verilog/cache_top.sv
module cache_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [cache_pkg::addr_width-1:0]    paddr,
    input  logic [cache_pkg::word_width-1:0]    pwdata,
    input  logic [cache_pkg::word_bytes-1:0]    pstrb,
    output logic [cache_pkg::word_width-1:0]    prdata,
    output logic                                pready,
    output logic                                pslverr
);

    cache_req_if apb_req ();
    cache_req_if bank_req ();
    mem_if       mem_bus ();

    logic                               rsp_valid;
    logic [cache_pkg::word_width-1:0]   rsp_data;

    apb_req_port u_apb (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req       (apb_req.producer),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    req_queue u_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (apb_req.consumer),
        .out   (bank_req.producer)
    );

    cache_bank u_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (bank_req.consumer),
        .mem       (mem_bus.bank),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    line_memory u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem_bus.memory)
    );

endmodule

// File: verilog/data_access.sv
module data_access (
    input  logic                                    clk,
    input  logic [cache_pkg::set_bits-1:0]          set,
    input  logic [cache_pkg::word_sel_bits-1:0]     wsel,
    input  logic                                    write,
    input  logic                                    fill,
    input  logic [cache_pkg::word_bytes-1:0]        byteen,
    input  logic [cache_pkg::word_width-1:0]        write_data,
    input  cache_pkg::line_t                        fill_data,
    input  logic [cache_pkg::num_ways-1:0]          way_sel,
    output logic [cache_pkg::word_width-1:0]        read_data
);

    cache_pkg::line_t                                               wdata;
    logic [cache_pkg::words_per_line-1:0][cache_pkg::word_bytes-1:0] wren;
    cache_pkg::line_t                                               way_rdata [cache_pkg::num_ways];
    cache_pkg::line_t                                               line_rdata;

    // A word write enables only the strobed bytes of one word
    always_comb begin
        if (write) begin
            wdata      = {cache_pkg::words_per_line{write_data}};
            wren       = '0;
            wren[wsel] = byteen;
        end else begin
            wdata = fill_data;
            wren  = {(cache_pkg::words_per_line * cache_pkg::word_bytes){fill}};
        end
    end

    for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
        cache_pkg::line_t ram [cache_pkg::num_sets];
        cache_pkg::line_t rdata_q;

        always_ff @(posedge clk) begin
            for (int i = 0; i < cache_pkg::words_per_line; i++) begin
                for (int b = 0; b < cache_pkg::word_bytes; b++) begin
                    if (wren[i][b] && way_sel[w]) begin
                        ram[set][i][b*8 +: 8] <= wdata[i][b*8 +: 8];
                    end
                end
            end
            rdata_q <= ram[set];
        end

        assign way_rdata[w] = rdata_q;
    end

    // One-hot way select
    always_comb begin
        line_rdata = '0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (way_sel[w]) begin
                line_rdata = line_rdata | way_rdata[w];
            end
        end
    end

    assign read_data = line_rdata[wsel];

endmodule

// File: verilog/line_memory.sv
module line_memory (
    input  logic   clk,
    input  logic   rst_n,
    mem_if.memory  mem
);

    cache_pkg::line_t                       lines [cache_pkg::mem_lines];
    logic [cache_pkg::mem_latency-1:0]      vld_pipe;
    logic [cache_pkg::line_addr_bits-1:0]   addr_pipe [cache_pkg::mem_latency];
    logic [cache_pkg::line_addr_bits-1:0]   wr_line;

    assign wr_line = {mem.wr_addr.tag, mem.wr_addr.set};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < cache_pkg::mem_lines; l++) begin
                lines[l] <= '0;
            end
        end else if (mem.wr_valid) begin
            for (int b = 0; b < cache_pkg::word_bytes; b++) begin
                if (mem.wr_strb[b]) begin
                    lines[wr_line][mem.wr_addr.wsel][b*8 +: 8] <= mem.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // Fixed latency delay line for read requests
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[cache_pkg::mem_latency-2:0], mem.rd_valid};
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= mem.rd_line;
        for (int i = 1; i < cache_pkg::mem_latency; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    assign mem.fill_valid = vld_pipe[cache_pkg::mem_latency-1];
    assign mem.fill_data  = lines[addr_pipe[cache_pkg::mem_latency-1]];

endmodule

// File: verilog/mem_if.sv
interface mem_if;

    // Word writes, one per cycle, never stalled
    logic                                   wr_valid;
    cache_pkg::word_addr_t                  wr_addr;
    logic [cache_pkg::word_width-1:0]       wr_data;
    logic [cache_pkg::word_bytes-1:0]       wr_strb;

    // Single cycle line read request
    logic                                   rd_valid;
    logic [cache_pkg::line_addr_bits-1:0]   rd_line;

    // Fill return, mem_latency cycles after rd_valid
    logic                                   fill_valid;
    cache_pkg::line_t                       fill_data;

    modport bank (
        output wr_valid, wr_addr, wr_data, wr_strb,
        output rd_valid, rd_line,
        input  fill_valid, fill_data
    );

    modport memory (
        input  wr_valid, wr_addr, wr_data, wr_strb,
        input  rd_valid, rd_line,
        output fill_valid, fill_data
    );

endinterface

// File: verilog/req_queue.sv
module req_queue (
    input  logic          clk,
    input  logic          rst_n,
    cache_req_if.consumer in,
    cache_req_if.producer out
);

    cache_pkg::cache_req_t                          slots [cache_pkg::queue_depth];
    logic [$clog2(cache_pkg::queue_depth)-1:0]      wr_ptr;
    logic [$clog2(cache_pkg::queue_depth)-1:0]      rd_ptr;
    logic [$clog2(cache_pkg::queue_depth):0]        count;
    logic                                           push;
    logic                                           pop;

    assign in.ready  = (count != cache_pkg::queue_depth);
    assign out.valid = (count != '0);
    assign out.req   = slots[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in.req;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule
